/* build.f */
logic/sortq_pkg.sv
logic/queue_cfg.sv
logic/queue_ctrl.sv
logic/sort_node.sv
logic/sort_queue_top.sv
test/sortq_model.sv
test/sort_queue_tb.sv

/* logic/queue_cfg.sv */
`default_nettype none

module queue_cfg import sortq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  wire        clk,
  input  wire        arst_n_i,
  input  wire        cfg_we_i,
  input  wire        cfg_descend_i,
  input  wire  [7:0] cfg_limit_i,
  input  wire        empty_i,
  output cfg_t       cfg_o,
  output logic       cfg_err_o
);

  localparam logic [7:0] DEPTH_L = 8'(DEPTH);

  cfg_t cfg_q;
  logic [7:0] limit_clamped;
  logic       wr_ok;

  // Out of range limits fall back to the physical depth
  always_comb begin
    if (cfg_limit_i == 8'd0 || cfg_limit_i > DEPTH_L) begin
      limit_clamped = DEPTH_L;
    end else begin
      limit_clamped = cfg_limit_i;
    end
  end

  // Order may only change with nothing stored
  assign wr_ok     = cfg_we_i && empty_i;
  assign cfg_err_o = cfg_we_i && !empty_i;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q.descend <= 1'b0;
      cfg_q.limit   <= DEPTH_L;
    end else if (wr_ok) begin
      cfg_q.descend <= cfg_descend_i;
      cfg_q.limit   <= limit_clamped;
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* logic/queue_ctrl.sv */
`default_nettype none

module queue_ctrl import sortq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  wire       clk,
  input  wire       arst_n_i,
  input  wire       push_i,
  input  wire       pop_i,
  input  wire cfg_t cfg_i,
  input  wire       cfg_err_i,
  output node_op_e  op_o,
  output status_t   status_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [7:0]       cnt_ext;
  logic             err_q;
  logic             empty;
  logic             below_limit;
  logic             push_ok;
  logic             pop_ok;
  logic             refused;

  assign cnt_ext     = 8'(cnt_q);
  assign empty       = (cnt_q == '0);
  assign below_limit = (cnt_ext < cfg_i.limit);

  ////////////////////////////////////////////////////////////////////////////
  // Acceptance and opcode
  ////////////////////////////////////////////////////////////////////////////

  // A pop frees the head, so a push at the limit still fits
  assign pop_ok  = pop_i && !empty;
  assign push_ok = push_i && (below_limit || pop_ok);
  assign refused = (push_i && !push_ok) || (pop_i && !pop_ok) || cfg_err_i;

  always_comb begin
    case ({push_ok, pop_ok})
      2'b10:   op_o = OP_PUSH;
      2'b01:   op_o = OP_POP;
      2'b11:   op_o = OP_PUSH_POP;
      default: op_o = OP_HOLD;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Occupancy and error pulse
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (push_ok && !pop_ok) begin
      cnt_q <= cnt_q + CNT_W'(1);
    end else if (pop_ok && !push_ok) begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  // One cycle wide, raised after any dropped strobe
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= refused;
    end
  end

  always_comb begin
    status_o.count = cnt_ext;
    status_o.empty = empty;
    status_o.full  = !below_limit;
    status_o.err   = err_q;
  end

endmodule

`default_nettype wire

/* logic/sort_node.sv */
`default_nettype none

module sort_node import sortq_pkg::*; #(
  parameter int KEY_W = 16
) (
  input  wire              clk,
  input  wire              arst_n_i,
  input  wire node_op_e    op_i,
  input  wire  [KEY_W-1:0] key_i,
  input  wire cfg_t        cfg_i,
  input  wire slot_t       left_slot_i,
  input  wire              left_beats_i,
  input  wire slot_t       right_slot_i,
  input  wire              right_beats_i,
  input  wire              is_head_i,
  output slot_t            slot_o,
  output logic             beats_o
);

  logic             valid_q;
  logic [KEY_W-1:0] key_q;
  slot_t            new_slot;
  slot_t            slot_n;
  logic             key_lt;
  logic             key_gt;

  always_comb begin
    slot_o                  = '0;
    slot_o.valid            = valid_q;
    slot_o.key[KEY_W-1:0]   = key_q;
    new_slot                = '0;
    new_slot.valid          = 1'b1;
    new_slot.key[KEY_W-1:0] = key_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare path
  ////////////////////////////////////////////////////////////////////////////

  // Strict compare keeps equal keys in arrival order
  assign key_lt  = (key_i < key_q);
  assign key_gt  = (key_i > key_q);
  assign beats_o = !valid_q || (cfg_i.descend ? key_gt : key_lt);

  ////////////////////////////////////////////////////////////////////////////
  // Slot update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    slot_n = slot_o;
    case (op_i)
      OP_HOLD: slot_n = slot_o;
      OP_PUSH: begin
        // Everything from the insertion point shifts right
        if (left_beats_i) begin
          slot_n = left_slot_i;
        end else if (beats_o) begin
          slot_n = new_slot;
        end
      end
      OP_POP:  slot_n = right_slot_i;
      OP_PUSH_POP: begin
        // Shift left up to the point where the new key lands
        if (!right_beats_i) begin
          slot_n = right_slot_i;
        end else if (is_head_i || !beats_o) begin
          slot_n = new_slot;
        end
      end
      default: slot_n = slot_o;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= slot_n.valid;
    end
  end

  always_ff @(posedge clk) begin
    key_q <= slot_n.key[KEY_W-1:0];
  end

endmodule

`default_nettype wire

/* logic/sort_queue_top.sv */
`default_nettype none

module sort_queue_top import sortq_pkg::*; #(
  parameter int DEPTH = 8,
  parameter int KEY_W = 16
) (
  input  wire              clk,
  input  wire              arst_n_i,
  input  wire              push_i,
  input  wire  [KEY_W-1:0] key_i,
  input  wire              pop_i,
  input  wire              cfg_we_i,
  input  wire              cfg_descend_i,
  input  wire        [7:0] cfg_limit_i,
  output slot_t            head_o,
  output status_t          status_o
);

  cfg_t     cfg;
  status_t  status;
  node_op_e op;
  logic     cfg_err;

  // Entry 0 and entry DEPTH+1 are the fixed chain ends, node i sits at i+1
  slot_t chain_slot  [DEPTH+2];
  logic  chain_beats [DEPTH+2];

  ////////////////////////////////////////////////////////////////////////////
  // Control side
  ////////////////////////////////////////////////////////////////////////////

  queue_cfg #(
    .DEPTH(DEPTH)
  ) u_cfg (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_descend_i(cfg_descend_i),
    .cfg_limit_i  (cfg_limit_i),
    .empty_i      (status.empty),
    .cfg_o        (cfg),
    .cfg_err_o    (cfg_err)
  );

  queue_ctrl #(
    .DEPTH(DEPTH)
  ) u_ctrl (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .push_i   (push_i),
    .pop_i    (pop_i),
    .cfg_i    (cfg),
    .cfg_err_i(cfg_err),
    .op_o     (op),
    .status_o (status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Node chain
  ////////////////////////////////////////////////////////////////////////////

  // Left end looks like a full slot the new key never passes
  assign chain_slot[0]        = '{valid: 1'b1, key: '0};
  assign chain_beats[0]       = 1'b0;
  // Right end is an empty slot, which every key beats
  assign chain_slot[DEPTH+1]  = '{valid: 1'b0, key: '0};
  assign chain_beats[DEPTH+1] = 1'b1;

  for (genvar i = 0; i < DEPTH; i++) begin : g_node
    sort_node #(
      .KEY_W(KEY_W)
    ) u_node (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .op_i         (op),
      .key_i        (key_i),
      .cfg_i        (cfg),
      .left_slot_i  (chain_slot[i]),
      .left_beats_i (chain_beats[i]),
      .right_slot_i (chain_slot[i+2]),
      .right_beats_i(chain_beats[i+2]),
      .is_head_i    (i == 0),
      .slot_o       (chain_slot[i+1]),
      .beats_o      (chain_beats[i+1])
    );
  end

  assign head_o   = chain_slot[1];
  assign status_o = status;

endmodule

`default_nettype wire

/* logic/sortq_pkg.sv */
`default_nettype none

package sortq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Node operation, broadcast to every slot of the chain each cycle
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_HOLD     = 2'd0,
    OP_PUSH     = 2'd1,
    OP_POP      = 2'd2,
    OP_PUSH_POP = 2'd3
  } node_op_e;

  // Key field is sized for the widest queue, nodes use the low KEY_W bits
  typedef struct packed {
    logic        valid;
    logic [31:0] key;
  } slot_t;

  // Limit of zero never reaches the queue, the config block clamps it
  typedef struct packed {
    logic       descend;
    logic [7:0] limit;
  } cfg_t;

  typedef struct packed {
    logic [7:0] count;
    logic       empty;
    logic       full;
    logic       err;
  } status_t;

endpackage

`default_nettype wire

/* test/sort_queue_tb.sv */
`default_nettype none

module sort_queue_tb import sortq_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH      = 8;
  localparam int KEY_W      = 16;
  localparam int CLK_PERIOD = 4;
  // Cycles per test including the two idle cycles that close each one
  localparam int TEST_CYCLES   = 18 + 21 + 210 + 19 + 210;
  localparam int MARGIN_CYCLES = 64;
  localparam int WATCHDOG_NS   = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic             clk;
  logic             arst_n;
  logic             push;
  logic [KEY_W-1:0] key;
  logic             pop;
  logic             cfg_we;
  logic             cfg_descend;
  logic [7:0]       cfg_limit;
  slot_t            head;
  status_t          status;
  slot_t            exp_head;
  status_t          exp_status;

  logic [31:0] rng_state    = 32'h8695_274b;
  int          err_count    = 0;
  int          err_mark     = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;

  sort_queue_top #(.DEPTH(DEPTH), .KEY_W(KEY_W)) uut (
    .clk(clk), .arst_n_i(arst_n), .push_i(push), .key_i(key), .pop_i(pop),
    .cfg_we_i(cfg_we), .cfg_descend_i(cfg_descend), .cfg_limit_i(cfg_limit),
    .head_o(head), .status_o(status)
  );

  sortq_model #(.DEPTH(DEPTH), .KEY_W(KEY_W)) u_model (
    .clk(clk), .arst_n_i(arst_n), .push_i(push), .key_i(key), .pop_i(pop),
    .cfg_we_i(cfg_we), .cfg_descend_i(cfg_descend), .cfg_limit_i(cfg_limit),
    .head_o(exp_head), .status_o(exp_status)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[ERROR] %s expected %h got %h at %0t ns", name, exp, act, $time);
    err_count++;
  endtask

  task automatic drive_cycle(input logic p, input logic [KEY_W-1:0] k, input logic q);
    @(negedge clk);
    push   = p;
    key    = k;
    pop    = q;
    cfg_we = 1'b0;
  endtask

  task automatic write_cfg(input logic d, input logic [7:0] lim);
    @(negedge clk);
    push        = 1'b0;
    pop         = 1'b0;
    cfg_we      = 1'b1;
    cfg_descend = d;
    cfg_limit   = lim;
  endtask

  task automatic finish_test(input string name);
    int new_errs;
    drive_cycle(1'b0, '0, 1'b0);
    drive_cycle(1'b0, '0, 1'b0);
    new_errs = err_count - err_mark;
    err_mark = err_count;
    tests_run++;
    if (new_errs > 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %0d errors", tests_run, name, new_errs);
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Checks against the model on every rising edge
  //////////////////////////////////////////////////////////////////////////////

  a_head_valid: assert property (@(posedge clk) disable iff (!arst_n)
      head.valid == exp_head.valid)
    else report_mismatch("head_o.valid", 32'($sampled(exp_head.valid)),
                         32'($sampled(head.valid)));

  a_head_key: assert property (@(posedge clk) disable iff (!arst_n)
      !exp_head.valid || head.key[KEY_W-1:0] == exp_head.key[KEY_W-1:0])
    else report_mismatch("head_o.key", 32'($sampled(exp_head.key[KEY_W-1:0])),
                         32'($sampled(head.key[KEY_W-1:0])));

  a_status: assert property (@(posedge clk) disable iff (!arst_n) status == exp_status)
    else report_mismatch("status_o", 32'($sampled(exp_status)), 32'($sampled(status)));

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]      rnd;
    logic [KEY_W-1:0] k;
    arst_n      = 1'b0;
    push        = 1'b0;
    key         = '0;
    pop         = 1'b0;
    cfg_we      = 1'b0;
    cfg_descend = 1'b0;
    cfg_limit   = '0;
    rnd         = '0;
    k           = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Every third key repeats the one before
    for (int i = 0; i < DEPTH; i++) begin
      if (i % 3 != 2) begin
        rnd = next_random();
        k   = rnd[KEY_W-1:0];
      end
      drive_cycle(1'b1, k, 1'b0);
    end
    repeat (DEPTH) drive_cycle(1'b0, '0, 1'b1);
    finish_test("ascending sort");

    for (int i = 0; i <= DEPTH; i++) begin
      rnd = next_random();
      drive_cycle(1'b1, rnd[KEY_W-1:0], 1'b0);
    end
    drive_cycle(1'b0, '0, 1'b0);
    repeat (DEPTH + 1) drive_cycle(1'b0, '0, 1'b1);
    finish_test("full and underflow");

    repeat (200) begin
      rnd = next_random();
      drive_cycle(rnd[0], rnd[31:16], rnd[1]);
    end
    repeat (DEPTH) drive_cycle(1'b0, '0, 1'b1);
    finish_test("push and pop together");

    write_cfg(1'b1, 8'd5);
    repeat (6) begin
      rnd = next_random();
      drive_cycle(1'b1, rnd[KEY_W-1:0], 1'b0);
    end
    write_cfg(1'b0, 8'd8);
    // New keys after the refused write still sort in descending order
    repeat (3) begin
      rnd = next_random();
      drive_cycle(1'b1, rnd[KEY_W-1:0], 1'b1);
    end
    repeat (5) drive_cycle(1'b0, '0, 1'b1);
    // Zero limit comes back as the full depth
    write_cfg(1'b0, 8'd0);
    finish_test("configuration");

    // Two-bit keys make most pushes tie with a stored key
    repeat (200) begin
      rnd = next_random();
      drive_cycle(rnd[0] | rnd[2], {14'd0, rnd[17:16]}, rnd[1]);
    end
    repeat (DEPTH) drive_cycle(1'b0, '0, 1'b1);
    finish_test("equal keys");

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/sortq_model.sv */
`default_nettype none

module sortq_model import sortq_pkg::*; #(
  parameter int DEPTH = 8,
  parameter int KEY_W = 16
) (
  input  wire              clk,
  input  wire              arst_n_i,
  input  wire              push_i,
  input  wire  [KEY_W-1:0] key_i,
  input  wire              pop_i,
  input  wire              cfg_we_i,
  input  wire              cfg_descend_i,
  input  wire        [7:0] cfg_limit_i,
  output slot_t            head_o,
  output status_t          status_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Keys kept in leaving order, index 0 is the head
  logic [KEY_W-1:0] keys[$];
  logic             descend;
  int               limit;
  logic             err;

  always @(posedge clk or negedge arst_n_i) begin : update
    logic pop_ok;
    logic push_ok;
    logic cfg_ok;
    int   pos;
    if (!arst_n_i) begin
      keys.delete();
      descend = 1'b0;
      limit   = DEPTH;
      err     = 1'b0;
    end else begin
      pop_ok  = pop_i && (keys.size() > 0);
      push_ok = push_i && ((keys.size() < limit) || pop_ok);
      cfg_ok  = cfg_we_i && (keys.size() == 0);
      err     = (push_i && !push_ok) || (pop_i && !pop_ok) || (cfg_we_i && !cfg_ok);
      if (pop_ok) begin
        void'(keys.pop_front());
      end
      // New key goes in front of the first key it strictly beats
      if (push_ok) begin
        pos = keys.size();
        for (int i = keys.size() - 1; i >= 0; i--) begin
          if (descend ? (key_i > keys[i]) : (key_i < keys[i])) begin
            pos = i;
          end
        end
        keys.insert(pos, key_i);
      end
      if (cfg_ok) begin
        descend = cfg_descend_i;
        limit   = (cfg_limit_i == 8'd0 || cfg_limit_i > DEPTH) ? DEPTH : int'(cfg_limit_i);
      end
    end
    head_o = '0;
    if (keys.size() > 0) begin
      head_o.valid            = 1'b1;
      head_o.key[KEY_W-1:0]   = keys[0];
    end
    status_o.count = 8'(keys.size());
    status_o.empty = (keys.size() == 0);
    status_o.full  = (keys.size() >= limit);
    status_o.err   = err;
  end

endmodule

`default_nettype wire
